//--- hdl/block_exec.sv
// Block header register bank
`include "miner_macros.svh"

module block_exec
  import miner_reg_pkg::*;
(
  input  logic    clk_main_a0,
  input  logic    rst_main_n_sync,
  input  blk_wr_t blk_wr,
  output block_t  block,
  output logic    new_block
);

  // Bit position width across the whole header
  localparam int unsigned lsb_w = $clog2($bits(block_t));

  logic [lsb_w-1:0] slot_lsb;

  // ---------------------------------------------------------------------------
  // Word placement
  // ---------------------------------------------------------------------------
  // Word 0 in the top slice and word 19 at the bottom
  always_comb begin
    slot_lsb = lsb_w'((`MINER_BLOCK_WORDS - 1 - int'(blk_wr.idx)) * `OCL_DATA_W);
  end

  // ---------------------------------------------------------------------------
  // Header bank
  // ---------------------------------------------------------------------------
  // Commanded word replaces its slice
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      block <= '0;
    end else if (blk_wr.valid) begin
      block[slot_lsb +: `OCL_DATA_W] <= blk_wr.data;
    end
  end

  // ---------------------------------------------------------------------------
  // Start pulse
  // ---------------------------------------------------------------------------
  // One cycle after the trigger word edge
  // Block already holds the new word when this is seen
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      new_block <= 1'b0;
    end else begin
      new_block <= blk_wr.valid && blk_wr.last;
    end
  end

  // ---------------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------------
  // Triggers never come back to back
  a_new_block_single : assert property (@(posedge clk_main_a0)
    disable iff (!rst_main_n_sync)
    new_block |=> !new_block);

endmodule

//--- hdl/miner_host_if.sv
// Miner host interface top
`include "miner_macros.svh"

module miner_host_if
  import ocl_bus_pkg::*;
  import miner_reg_pkg::*;
(
  input  logic     clk_main_a0,
  input  logic     rst_main_n_sync,
  input  ocl_req_t ocl_req,
  output ocl_rsp_t ocl_rsp,
  output block_t   block,
  output logic     new_block,
  input  logic     nonce_found,
  input  nonce_t   nonce
);

  blk_wr_t                blk_wr;
  rd_req_t                rd_req;
  logic                   rvalid;
  logic [`OCL_DATA_W-1:0] rdata;
  ocl_resp_e              rresp;

  // ---------------------------------------------------------------------------
  // Channel control and decode
  // ---------------------------------------------------------------------------
  ocl_decode u_ocl_decode (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .req             (ocl_req),
    .rvalid          (rvalid),
    .awready         (ocl_rsp.awready),
    .wready          (ocl_rsp.wready),
    .bvalid          (ocl_rsp.bvalid),
    .bresp           (ocl_rsp.bresp),
    .arready         (ocl_rsp.arready),
    .blk_wr          (blk_wr),
    .rd_req          (rd_req)
  );

  // Header bank toward the hashing core
  block_exec u_block_exec (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .blk_wr          (blk_wr),
    .block           (block),
    .new_block       (new_block)
  );

  // Nonce back from the core, read side
  ocl_result u_ocl_result (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .rd_req          (rd_req),
    .rready          (ocl_req.rready),
    .nonce_found     (nonce_found),
    .nonce           (nonce),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp)
  );

  // Read channel fields into the response bundle
  assign ocl_rsp.rvalid = rvalid;
  assign ocl_rsp.rdata  = rdata;
  assign ocl_rsp.rresp  = rresp;

endmodule

//--- hdl/miner_macros.svh
// Miner host register map
`ifndef MINER_MACROS_SVH
`define MINER_MACROS_SVH

// ---------------------------------------------------------------------------
// Host bus widths
// ---------------------------------------------------------------------------
`define OCL_ADDR_W 32
`define OCL_DATA_W 32

// ---------------------------------------------------------------------------
// Block header window
// ---------------------------------------------------------------------------
// Twenty words, word 0 first
`define MINER_BLOCK_WORDS 20

// First block word
`define MINER_BLOCK_BASE 32'h0000_0504

// Last block word, a write here starts the miner
`define MINER_BLOCK_LAST 32'h0000_0550

// ---------------------------------------------------------------------------
// Result and unmapped reads
// ---------------------------------------------------------------------------
// Nonce result, read only
`define MINER_RESULT_ADDR 32'h0000_0554

// Returned for every other read address
`define MINER_READ_MISS {`OCL_DATA_W{1'b1}}

`endif

//--- hdl/miner_reg_pkg.sv
// Miner register types
`include "miner_macros.svh"

package miner_reg_pkg;

  // -------------------------------------------------------------------------
  // Miner side payloads
  // -------------------------------------------------------------------------
  // Full header, word 0 in the top 32 bits
  typedef logic [`MINER_BLOCK_WORDS*`OCL_DATA_W-1:0] block_t;

  // Nonce reported back by the hashing core
  typedef logic [31:0] nonce_t;

  // Word position inside the header
  typedef logic [$clog2(`MINER_BLOCK_WORDS)-1:0] word_idx_t;

  // -------------------------------------------------------------------------
  // Internal commands between decode and the register blocks
  // -------------------------------------------------------------------------
  // One block word write, valid for a single cycle
  typedef struct packed {
    logic                   valid;
    word_idx_t              idx;
    logic [`OCL_DATA_W-1:0] data;
    // Trigger word, kicks off a new search
    logic                   last;
  } blk_wr_t;

  // Registered read request
  typedef struct packed {
    logic valid;
    // Address matched the result register
    logic hit_result;
  } rd_req_t;

endpackage

//--- hdl/ocl_bus_pkg.sv
// Host AXI-Lite bundles
`include "miner_macros.svh"

package ocl_bus_pkg;

  // AXI response codes
  // Only okay leaves this slave
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } ocl_resp_e;

  // -------------------------------------------------------------------------
  // Host to slave
  // -------------------------------------------------------------------------
  typedef struct packed {
    // Write address
    logic                      awvalid;
    logic [`OCL_ADDR_W-1:0]    awaddr;
    // Write data, strobes carried but not acted on
    logic                      wvalid;
    logic [`OCL_DATA_W-1:0]    wdata;
    logic [`OCL_DATA_W/8-1:0]  wstrb;
    // Write response accept
    logic                      bready;
    // Read address
    logic                      arvalid;
    logic [`OCL_ADDR_W-1:0]    araddr;
    // Read data accept
    logic                      rready;
  } ocl_req_t;

  // -------------------------------------------------------------------------
  // Slave to host
  // -------------------------------------------------------------------------
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    ocl_resp_e              bresp;
    logic                   arready;
    logic                   rvalid;
    logic [`OCL_DATA_W-1:0] rdata;
    ocl_resp_e              rresp;
  } ocl_rsp_t;

endpackage

//--- hdl/ocl_decode.sv
// AXI-Lite channel control and decode
`include "miner_macros.svh"

module ocl_decode
  import ocl_bus_pkg::*;
  import miner_reg_pkg::*;
(
  input  logic      clk_main_a0,
  input  logic      rst_main_n_sync,
  input  ocl_req_t  req,
  input  logic      rvalid,
  output logic      awready,
  output logic      wready,
  output logic      bvalid,
  output ocl_resp_e bresp,
  output logic      arready,
  output blk_wr_t   blk_wr,
  output rd_req_t   rd_req
);

  // Byte span of the block window
  localparam int unsigned block_span = `MINER_BLOCK_WORDS * (`OCL_DATA_W / 8);

  logic                   wr_active;
  logic [`OCL_ADDR_W-1:0] wr_addr;
  logic [`OCL_ADDR_W-1:0] wr_off;
  logic                   wr_in_block;

  // ---------------------------------------------------------------------------
  // Write address and data
  // ---------------------------------------------------------------------------
  // One write in flight until B completes
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
    end else if (wr_active && bvalid && req.bready) begin
      wr_active <= 1'b0;
    end else if (!wr_active && req.awvalid) begin
      wr_active <= 1'b1;
    end
  end

  // Address captured on the AW handshake
  always_ff @(posedge clk_main_a0) begin
    if (awready && req.awvalid) begin
      wr_addr <= req.awaddr;
    end
  end

  assign awready = !wr_active;
  assign wready  = wr_active && req.wvalid;

  // Offset into the block window
  // Addresses below the base wrap high and miss
  assign wr_off      = wr_addr - `MINER_BLOCK_BASE;
  assign wr_in_block = (wr_off < `OCL_ADDR_W'(block_span)) && (wr_off[1:0] == 2'b00);

  // Command lives in the W beat cycle only
  // Strobes ignored and the whole word written
  assign blk_wr.valid = wready && wr_in_block;
  assign blk_wr.idx   = wr_off[$bits(word_idx_t)+1:2];
  assign blk_wr.data  = req.wdata;
  assign blk_wr.last  = wr_addr == `MINER_BLOCK_LAST;

  // ---------------------------------------------------------------------------
  // Write response
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      bvalid <= 1'b0;
    end else if (bvalid && req.bready) begin
      bvalid <= 1'b0;
    end else if (wready) begin
      bvalid <= 1'b1;
    end
  end

  // Unmapped writes complete as well
  assign bresp = resp_okay;

  // ---------------------------------------------------------------------------
  // Read request
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_req <= '0;
    end else begin
      rd_req.valid      <= req.arvalid && arready;
      rd_req.hit_result <= req.araddr == `MINER_RESULT_ADDR;
    end
  end

  // Blocked while a request is queued or data waits
  assign arready = !rd_req.valid && !rvalid;

  // ---------------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------------
  // No second W beat while B is still pending
  a_w_one_beat : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    wready |-> !bvalid);

endmodule

//--- hdl/ocl_result.sv
// Nonce result and read response
`include "miner_macros.svh"

module ocl_result
  import ocl_bus_pkg::*;
  import miner_reg_pkg::*;
(
  input  logic                   clk_main_a0,
  input  logic                   rst_main_n_sync,
  input  rd_req_t                rd_req,
  input  logic                   rready,
  input  logic                   nonce_found,
  input  nonce_t                 nonce,
  output logic                   rvalid,
  output logic [`OCL_DATA_W-1:0] rdata,
  output ocl_resp_e              rresp
);

  nonce_t result;

  // ---------------------------------------------------------------------------
  // Result capture
  // ---------------------------------------------------------------------------
  // Latest nonce wins, held until the next find
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      result <= '0;
    end else if (nonce_found) begin
      result <= nonce;
    end
  end

  // ---------------------------------------------------------------------------
  // Read valid
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rvalid <= 1'b0;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
    end else if (rd_req.valid) begin
      rvalid <= 1'b1;
    end
  end

  // ---------------------------------------------------------------------------
  // Read data
  // ---------------------------------------------------------------------------
  // Loaded once per request, frozen while rvalid waits
  // Decode holds off new requests until rvalid drops
  always_ff @(posedge clk_main_a0) begin
    if (rd_req.valid) begin
      if (rd_req.hit_result) begin
        rdata <= `OCL_DATA_W'(result);
      end else begin
        rdata <= `MINER_READ_MISS;
      end
    end
  end

  // Misses still answer okay
  assign rresp = resp_okay;

  // ---------------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------------
  // Data must not move under a stalled host
  a_rdata_stable : assert property (@(posedge clk_main_a0)
    disable iff (!rst_main_n_sync)
    rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

//--- run.sh
#!/bin/sh
# Build and run the miner host interface testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tb_miner_host_if \
  -f src.f -o sim_miner_host_if --Mdir obj_dir
./obj_dir/sim_miner_host_if > sim.log 2>&1 || true
cat sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
  exit 0
fi
exit 1

//--- src.f
+incdir+hdl
hdl/ocl_bus_pkg.sv
hdl/miner_reg_pkg.sv
hdl/ocl_decode.sv
hdl/block_exec.sv
hdl/ocl_result.sv
hdl/miner_host_if.sv
verif/tb_miner_host_if.sv

//--- verif/miner_host_if_trace.txt
# op a d, all hex
# W addr data | R addr expected | N nonce | B word_index expected
R 554 00000000
W 504 00000002
W 508 a7c3e51f
W 50c 3d9b0f64
W 510 8e21c7a0
W 514 5f4e92d3
W 518 c0ffee11
W 51c 19a8b76e
W 520 7734d2c5
W 524 e6105fa9
W 528 2b9c4e08
W 52c 91d7a3f6
W 530 4c5e1b72
W 534 d3a86c9e
W 538 0f62b415
W 53c b84d27e0
W 540 63e9f1ac
W 544 aa55c3d7
W 548 5e7b0c49
W 54c 1702f8be
W 550 9ab4e163
B 00 00000002
B 13 9ab4e163
N 5a3c91e7
R 554 5a3c91e7
R 528 ffffffff
W 600 deadbeef
B 00 00000002

//--- verif/tb_miner_host_if.sv
// Miner host interface testbench
`include "miner_macros.svh"

module tb_miner_host_if
  import ocl_bus_pkg::*;
  import miner_reg_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int timeout_cycles = 100;

  logic     clk_main_a0;
  logic     rst_main_n_sync;
  ocl_req_t ocl_req;
  ocl_rsp_t ocl_rsp;
  block_t   block;
  logic     new_block;
  logic     nonce_found;
  nonce_t   nonce;

  // Reference header built from the trace writes
  block_t      exp_block;
  logic [15:0] lfsr;
  int          errors = 0;
  int          pulses = 0;
  int          triggers = 0;

  miner_host_if u_miner_host_if (.*);

  initial begin
    clk_main_a0 = 1'b0;
    forever #5 clk_main_a0 = ~clk_main_a0;
  end

  // Start pulses seen by the hashing core
  always @(posedge clk_main_a0) begin
    if (rst_main_n_sync && new_block) pulses++;
  end

  // ---------------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------------
  // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) lfsr = lfsr ^ 16'hb400;
    return out;
  endfunction

  // Host stall of 0 to 7 cycles
  function automatic int pick_delay();
    int d;
    d = 0;
    repeat (3) d = (d << 1) | int'(lfsr_bit());
    return d;
  endfunction

  task automatic report_mismatch(input string name, input logic [$bits(block_t)-1:0] got,
                                 input logic [$bits(block_t)-1:0] exp);
    errors++;
    $display("ERROR %s got %0h expected %0h at %0t", name, got, exp, $time);
  endtask

  // Inputs change just after the edge
  task automatic next_cycle();
    @(posedge clk_main_a0);
    #1;
  endtask

  // ---------------------------------------------------------------------------
  // AXI-Lite host
  // ---------------------------------------------------------------------------
  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    int waited;
    int stall;
    waited = 0;
    while (!ocl_rsp.awready && waited < timeout_cycles) begin
      next_cycle();
      waited++;
    end
    if (!ocl_rsp.awready) begin
      errors++;
      $display("Write to %h never saw awready", addr);
    end
    ocl_req.awvalid = 1'b1;
    ocl_req.awaddr  = addr;
    next_cycle();
    // Data beat follows the taken address
    ocl_req.awvalid = 1'b0;
    ocl_req.wvalid  = 1'b1;
    ocl_req.wdata   = data;
    ocl_req.wstrb   = 4'hf;
    // wready answers wvalid within the same cycle
    #1;
    if (!ocl_rsp.wready) report_mismatch("wready", ocl_rsp.wready, 1);
    next_cycle();
    ocl_req.wvalid = 1'b0;
    waited = 0;
    while (!ocl_rsp.bvalid && waited < timeout_cycles) begin
      next_cycle();
      waited++;
    end
    if (!ocl_rsp.bvalid) begin
      errors++;
      $display("Write to %h never got a write response", addr);
    end
    // Slave keeps B and refuses new addresses while bready is low
    stall = pick_delay();
    repeat (stall) begin
      if (!ocl_rsp.bvalid) report_mismatch("bvalid", ocl_rsp.bvalid, 1);
      if (ocl_rsp.awready) report_mismatch("awready", ocl_rsp.awready, 0);
      next_cycle();
    end
    if (ocl_rsp.bresp != resp_okay) report_mismatch("bresp", ocl_rsp.bresp, resp_okay);
    ocl_req.bready = 1'b1;
    next_cycle();
    ocl_req.bready = 1'b0;
    // Word 0 sits in the top slice
    if (addr >= `MINER_BLOCK_BASE && addr <= `MINER_BLOCK_LAST && addr[1:0] == 2'b00) begin
      exp_block[(`MINER_BLOCK_WORDS - 1 - int'((addr - `MINER_BLOCK_BASE) >> 2)) * 32 +: 32]
        = data;
    end
    if (addr == `MINER_BLOCK_LAST) triggers++;
    if (block != exp_block) report_mismatch("block", block, exp_block);
  endtask

  task automatic read_reg(input logic [31:0] addr, input logic [31:0] exp);
    int          waited;
    int          stall;
    logic [31:0] first;
    waited = 0;
    while (!ocl_rsp.arready && waited < timeout_cycles) begin
      next_cycle();
      waited++;
    end
    if (!ocl_rsp.arready) begin
      errors++;
      $display("Read of %h never saw arready", addr);
    end
    ocl_req.arvalid = 1'b1;
    ocl_req.araddr  = addr;
    next_cycle();
    ocl_req.arvalid = 1'b0;
    waited = 0;
    while (!ocl_rsp.rvalid && waited < timeout_cycles) begin
      next_cycle();
      waited++;
    end
    if (!ocl_rsp.rvalid) begin
      errors++;
      $display("Read of %h never returned data", addr);
    end
    first = ocl_rsp.rdata;
    stall = pick_delay();
    repeat (stall) begin
      if (!ocl_rsp.rvalid) report_mismatch("rvalid", ocl_rsp.rvalid, 1);
      if (ocl_rsp.rdata != first) report_mismatch("rdata", ocl_rsp.rdata, first);
      next_cycle();
    end
    if (ocl_rsp.rdata != exp) report_mismatch("rdata", ocl_rsp.rdata, exp);
    if (ocl_rsp.rresp != resp_okay) report_mismatch("rresp", ocl_rsp.rresp, resp_okay);
    ocl_req.rready = 1'b1;
    next_cycle();
    ocl_req.rready = 1'b0;
  endtask

  // ---------------------------------------------------------------------------
  // Trace run
  // ---------------------------------------------------------------------------
  initial begin
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] d;
    lfsr            = 16'h0001;
    exp_block       = '0;
    ocl_req         = '0;
    nonce_found     = 1'b0;
    nonce           = '0;
    rst_main_n_sync = 1'b0;
    repeat (8) next_cycle();
    rst_main_n_sync = 1'b1;
    next_cycle();
    if (ocl_rsp.bvalid) report_mismatch("bvalid", ocl_rsp.bvalid, 0);
    if (ocl_rsp.rvalid) report_mismatch("rvalid", ocl_rsp.rvalid, 0);
    if (new_block) report_mismatch("new_block", new_block, 0);
    fd = $fopen("verif/miner_host_if_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the trace file");
    end else begin
      while (!$feof(fd)) begin
        op = 8'h00;
        n  = $fgets(line, fd);
        if (n > 0) n = $sscanf(line, "%c %h %h", op, a, d);
        // Comment and blank lines fall to the default
        case (op)
          "W": write_reg(a, d);
          "R": read_reg(a, d);
          "N": begin
            nonce       = a;
            nonce_found = 1'b1;
            next_cycle();
            nonce_found = 1'b0;
          end
          "B": begin
            if (block[(`MINER_BLOCK_WORDS - 1 - int'(a)) * 32 +: 32] != d)
              report_mismatch("block word", block[(`MINER_BLOCK_WORDS - 1 - int'(a)) * 32 +: 32], d);
          end
          default: ;
        endcase
      end
      $fclose(fd);
    end
    repeat (3) next_cycle();
    if (pulses != triggers) report_mismatch("new_block pulses", pulses, triggers);
    $display("Run complete with %0d errors, %0d start pulses for %0d trigger writes",
             errors, pulses, triggers);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
